// File: list.f
rtl/mem_pkg.sv
rtl/load_align.sv
rtl/apb_data_port.sv
rtl/data_ram.sv
rtl/int_regfile.sv
rtl/mem_stage_ctrl.sv
rtl/mem_subsystem.sv
tests/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - rtl/mem_pkg.sv
  - rtl/load_align.sv
  - rtl/apb_data_port.sv
  - rtl/data_ram.sv
  - rtl/int_regfile.sv
  - rtl/mem_stage_ctrl.sv
  - rtl/mem_subsystem.sv
  - target: test
    files:
      - tests/tb_mem_subsystem.sv

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem import mem_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int INSTR_COUNT = 200;  // Instructions and register reads of all tests, rounded up
  localparam int MARGIN_NS   = 200 * CLK_PERIOD;
  localparam int MEM_BYTES   = RAM_WORDS * NBYTES;

  logic      clk;
  logic      rst;
  ex_mem_t   ex_in;
  logic      flush;
  logic      stall;
  mem_exc_t  exc;
  reg_addr_t rd_addr;
  xlen_t     rd_data;

  logic [7:0] mem_model [MEM_BYTES];
  xlen_t      reg_model [NUM_REGS];
  integer     seed = 32'h2041_60d7;
  int         errors;
  int         tests;
  int         failed_tests;
  int         exc_count;
  ecause_t    exc_cause;
  addr_t      exc_tval;

  mem_subsystem dut0 (
    .clk     (clk),
    .rst     (rst),
    .ex_in   (ex_in),
    .flush   (flush),
    .stall   (stall),
    .exc     (exc),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Exceptions are counted per cycle, sampled away from the clock edges
  always @(negedge clk) begin
    if (exc.valid) begin
      exc_count++;
      exc_cause = exc.cause;
      exc_tval  = exc.tval;
    end
  end

  initial begin
    #(INSTR_COUNT * (3 + RAM_WAIT) * CLK_PERIOD + MARGIN_NS);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic is_load_op(lsu_op_e op);
    return op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
  endfunction

  function automatic logic misaligned_addr(lsu_op_e op, addr_t a);
    if (op inside {LSU_LH, LSU_LHU, LSU_SH}) return a[0];
    if (op inside {LSU_LW, LSU_SW}) return a[1:0] != 2'b00;
    return 1'b0;
  endfunction

  function automatic ex_mem_t alu_instr(reg_addr_t rd, xlen_t data);
    ex_mem_t ins;
    ins        = '0;
    ins.valid  = 1'b1;
    ins.wren   = 1'b1;
    ins.waddr  = rd;
    ins.wdata  = data;
    ins.lsu_op = LSU_NONE;
    return ins;
  endfunction

  function automatic ex_mem_t mem_instr(lsu_op_e op, reg_addr_t rd, addr_t a, xlen_t sd);
    ex_mem_t ins;
    ins        = '0;
    ins.valid  = 1'b1;
    ins.wren   = is_load_op(op);
    ins.waddr  = rd;
    ins.wdata  = ~sd;  // ALU result of a memory op is never written back
    ins.lsu_op = op;
    ins.addr   = a;
    ins.sdata  = sd;
    return ins;
  endfunction

  // Differs for every word address
  function automatic xlen_t fill_word(addr_t a);
    return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic void apply_model(ex_mem_t ins);
    int    i;
    int    n;
    xlen_t v;
    i = ins.addr[RAM_AW+1:0];
    if (misaligned_addr(ins.lsu_op, ins.addr)) return;
    case (ins.lsu_op)
      LSU_LB:  v = {{24{mem_model[i][7]}}, mem_model[i]};
      LSU_LBU: v = {24'h0, mem_model[i]};
      LSU_LH:  v = {{16{mem_model[i+1][7]}}, mem_model[i+1], mem_model[i]};
      LSU_LHU: v = {16'h0, mem_model[i+1], mem_model[i]};
      LSU_LW:  v = {mem_model[i+3], mem_model[i+2], mem_model[i+1], mem_model[i]};
      default: v = ins.wdata;
    endcase
    case (ins.lsu_op)
      LSU_SB:  n = 1;
      LSU_SH:  n = 2;
      LSU_SW:  n = 4;
      default: n = 0;
    endcase
    for (int b = 0; b < n; b++) begin
      mem_model[i + b] = ins.sdata[8*b +: 8];
    end
    if (n == 0 && ins.wren && ins.waddr != '0) begin
      reg_model[ins.waddr] = v;
    end
  endfunction

  task automatic value_error(input string name, input xlen_t expected, input xlen_t actual);
    $display("Error %s: expected %h, actual %h", name, expected, actual);
    errors++;
  endtask

  task automatic send_instr(input ex_mem_t ins);
    ex_in = ins;
    while (stall) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // Accepted at this edge
    #2;
    ex_in = '0;
  endtask

  task automatic wait_idle(output int cycles);
    cycles = 0;
    while (stall) begin
      cycles++;
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // Writeback edge
    #2;
  endtask

  task automatic read_reg(input reg_addr_t idx, output xlen_t val);
    rd_addr = idx;
    #1;
    val = rd_data;
    @(posedge clk);
    #2;
  endtask

  task automatic exec_check(input ex_mem_t ins, input string name, input logic flushed);
    int      cycles;
    int      exc_before;
    int      exp_stall;
    int      exp_exc;
    logic    bad;
    ecause_t exp_cause;
    xlen_t   val;
    exc_before = exc_count;
    bad        = misaligned_addr(ins.lsu_op, ins.addr);
    exp_cause  = is_load_op(ins.lsu_op) ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
    exp_stall  = (flushed || bad || ins.lsu_op == LSU_NONE) ? 0 : 2 + RAM_WAIT;
    exp_exc    = (bad && !flushed) ? 1 : 0;
    send_instr(ins);
    if (flushed) begin
      flush = 1'b1;  // First cycle in the stage
      @(posedge clk);
      #2;
      flush = 1'b0;
    end
    wait_idle(cycles);
    if (!flushed) begin
      apply_model(ins);
    end
    if (cycles != exp_stall) begin
      value_error({name, " stall cycles"}, exp_stall, cycles);
    end
    if (exc_count - exc_before != exp_exc) begin
      value_error({name, " exception cycles"}, exp_exc, exc_count - exc_before);
    end
    if (exp_exc == 1 && exc_cause !== exp_cause) begin
      value_error({name, " cause"}, exp_cause, exc_cause);
    end
    if (exp_exc == 1 && exc_tval !== ins.addr) begin
      value_error({name, " tval"}, ins.addr, exc_tval);
    end
    if (ins.wren) begin
      read_reg(ins.waddr, val);
      if (val !== reg_model[ins.waddr]) begin
        value_error(name, reg_model[ins.waddr], val);
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic alu_writeback();
    int start;
    start = errors;
    exec_check(alu_instr(5'd1, 32'h1234_5678), "alu x1", 1'b0);
    exec_check(alu_instr(5'd2, 32'hdead_beef), "alu x2", 1'b0);
    exec_check(alu_instr(5'd31, 32'h8000_0001), "alu x31", 1'b0);
    exec_check(alu_instr(5'd0, 32'hffff_ffff), "alu x0", 1'b0);
    exec_check(alu_instr(5'd1, 32'h0000_0000), "alu x1 rewrite", 1'b0);
    finish_test("alu_writeback", start);
  endtask

  task automatic word_store_load();
    int start;
    start = errors;
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h20, 32'hcafe_f00d), "sw 0x20", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd3, 32'h20, '0), "lw 0x20", 1'b0);
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h3fc, 32'h0bad_c0de), "sw 0x3fc", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd4, 32'h3fc, '0), "lw 0x3fc", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd5, 32'h7fc, '0), "lw wrapped", 1'b0);
    finish_test("word_store_load", start);
  endtask

  task automatic subword_access();
    int    start;
    addr_t a;
    start = errors;
    for (int l = 0; l < 4; l++) begin
      a = 32'h40 + 4 * l;
      exec_check(mem_instr(LSU_SW, 5'd0, a, fill_word(a)), "sb prefill", 1'b0);
      exec_check(mem_instr(LSU_SB, 5'd0, a + l, {24'hfedcba, 8'h39 + 8'(48 * l)}), "sb", 1'b0);
      exec_check(mem_instr(LSU_LB, 5'd6, a + l, '0), $sformatf("lb lane %0d", l), 1'b0);
      exec_check(mem_instr(LSU_LBU, 5'd7, a + l, '0), $sformatf("lbu lane %0d", l), 1'b0);
      exec_check(mem_instr(LSU_LB, 5'd8, a + (l ^ 1), '0), $sformatf("lb near %0d", l), 1'b0);
      exec_check(mem_instr(LSU_LW, 5'd9, a, '0), $sformatf("lw after sb %0d", l), 1'b0);
    end
    for (int h = 0; h < 2; h++) begin
      a = 32'h50 + 4 * h;
      exec_check(mem_instr(LSU_SW, 5'd0, a, fill_word(a)), "sh prefill", 1'b0);
      exec_check(mem_instr(LSU_SH, 5'd0, a + 2 * h, (h == 1) ? 32'h2468_8642 : 32'h2468_7531),
                 "sh", 1'b0);
      exec_check(mem_instr(LSU_LH, 5'd10, a + 2 * h, '0), $sformatf("lh lane %0d", 2 * h), 1'b0);
      exec_check(mem_instr(LSU_LHU, 5'd11, a + 2 * h, '0), $sformatf("lhu lane %0d", 2 * h), 1'b0);
      exec_check(mem_instr(LSU_LH, 5'd12, a + 2 * (1 - h), '0), "lh other half", 1'b0);
      exec_check(mem_instr(LSU_LW, 5'd13, a, '0), $sformatf("lw after sh %0d", h), 1'b0);
    end
    finish_test("subword_access", start);
  endtask

  task automatic misaligned_access();
    int start;
    start = errors;
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h60, fill_word(32'h60)), "prefill 0x60", 1'b0);
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h64, fill_word(32'h64)), "prefill 0x64", 1'b0);
    exec_check(alu_instr(5'd14, 32'h1111_1111), "alu x14", 1'b0);
    exec_check(mem_instr(LSU_LH, 5'd14, 32'h61, '0), "lh 0x61", 1'b0);
    exec_check(mem_instr(LSU_LHU, 5'd14, 32'h63, '0), "lhu 0x63", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd14, 32'h62, '0), "lw 0x62", 1'b0);
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h65, 32'hffff_ffff), "sw 0x65", 1'b0);
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h63, 32'hffff_ffff), "sw 0x63", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd15, 32'h60, '0), "lw 0x60 after", 1'b0);
    exec_check(mem_instr(LSU_LW, 5'd15, 32'h64, '0), "lw 0x64 after", 1'b0);
    finish_test("misaligned_access", start);
  endtask

  task automatic flush_drop();
    int start;
    start = errors;
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h70, fill_word(32'h70)), "prefill 0x70", 1'b0);
    exec_check(alu_instr(5'd20, 32'haaaa_5555), "flushed alu", 1'b1);
    exec_check(mem_instr(LSU_SW, 5'd0, 32'h70, 32'h0), "flushed sw", 1'b1);
    exec_check(mem_instr(LSU_LW, 5'd20, 32'h70, '0), "flushed lw", 1'b1);
    exec_check(mem_instr(LSU_LW, 5'd21, 32'h71, '0), "flushed misaligned lw", 1'b1);
    exec_check(mem_instr(LSU_LW, 5'd22, 32'h70, '0), "lw after flush", 1'b0);
    exec_check(alu_instr(5'd23, 32'h0f0f_f0f0), "alu after flush", 1'b0);
    finish_test("flush_drop", start);
  endtask

  task automatic mixed_stream();
    int      start;
    int      exc_before;
    int      cycles;
    integer  rnd;
    lsu_op_e op;
    addr_t   a;
    ex_mem_t ins;
    xlen_t   val;
    start      = errors;
    exc_before = exc_count;
    for (int w = 0; w < 16; w++) begin  // Defined contents for every load of the stream
      a   = 32'h100 + 4 * w;
      ins = mem_instr(LSU_SW, 5'd0, a, fill_word(a));
      send_instr(ins);
      apply_model(ins);
    end
    for (int n = 0; n < 40; n++) begin
      rnd = $random(seed);
      op  = lsu_op_e'(rnd[7:0] % 9);
      a   = 32'h100 + rnd[13:8];
      if (op inside {LSU_LH, LSU_LHU, LSU_SH}) a[0] = 1'b0;
      if (op inside {LSU_LW, LSU_SW}) a[1:0] = 2'b00;
      if (op == LSU_NONE) begin
        ins      = alu_instr(rnd[20:16], $random(seed));
        ins.wren = rnd[24];
      end else begin
        ins = mem_instr(op, rnd[20:16], a, $random(seed));
      end
      send_instr(ins);
      apply_model(ins);
    end
    wait_idle(cycles);
    if (exc_count != exc_before) begin
      $display("Mixed stream raised an exception on an aligned access");
      errors++;
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      read_reg(reg_addr_t'(i), val);
      if (val !== reg_model[i]) begin
        value_error($sformatf("stream x%0d", i), reg_model[i], val);
      end
    end
    finish_test("mixed_stream", start);
  endtask

  initial begin
    ex_in        = '0;
    flush        = 1'b0;
    rd_addr      = '0;
    rst          = 1'b0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    exc_count    = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      reg_model[i] = '0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b1;
    alu_writeback();
    word_store_load();
    subword_access();
    misaligned_access();
    flush_drop();
    mixed_stream();
    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: rtl/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  ex_mem_t   ex_in,
  input  logic      flush,
  output logic      stall,
  output mem_exc_t  exc,
  input  reg_addr_t rd_addr,
  output xlen_t     rd_data
);

  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  xlen_t      ld_raw;
  xlen_t      ld_data;
  logic [1:0] ld_addr_lo;
  lsu_op_e    ld_op;
  reg_write_t reg_win;

  mem_stage_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .ex_in      (ex_in),
    .flush      (flush),
    .stall      (stall),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .ld_data    (ld_data),
    .ld_raw     (ld_raw),
    .ld_addr_lo (ld_addr_lo),
    .ld_op      (ld_op),
    .reg_win    (reg_win),
    .exc        (exc)
  );

  apb_data_port u_port (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .apb_out (apb_req),
    .apb_in  (apb_rsp)
  );

  load_align u_align (
    .raw     (ld_raw),
    .addr_lo (ld_addr_lo),
    .op      (ld_op),
    .data    (ld_data)
  );

  data_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .apb_in  (apb_req),
    .apb_out (apb_rsp)
  );

  int_regfile u_regs (
    .clk     (clk),
    .rst     (rst),
    .reg_win (reg_win),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// File: rtl/mem_stage_ctrl.sv
`timescale 1ns/100ps

module mem_stage_ctrl import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ex_mem_t    ex_in,
  input  logic       flush,
  output logic       stall,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  input  xlen_t      ld_data,
  output xlen_t      ld_raw,
  output logic [1:0] ld_addr_lo,
  output lsu_op_e    ld_op,
  output reg_write_t reg_win,
  output mem_exc_t   exc
);

  ex_mem_t r;
  logic    busy;
  logic    pending;  // A transfer is running in the port
  logic    drain;    // The running transfer belongs to a flushed instruction
  logic    r_mem;
  logic    r_misaligned;
  logic    req_raw;
  logic    done_own;

  function automatic logic is_mem(lsu_op_e op);
    return op != LSU_NONE;
  endfunction

  function automatic logic is_load(lsu_op_e op);
    return op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
  endfunction

  function automatic logic misaligned(lsu_op_e op, addr_t addr);
    logic bad;
    case (op)
      LSU_LH, LSU_LHU, LSU_SH: bad = addr[0];
      LSU_LW, LSU_SW:          bad = |addr[1:0];
      default:                 bad = 1'b0;
    endcase
    return bad;
  endfunction

  assign r_mem        = r.valid && is_mem(r.lsu_op);
  assign r_misaligned = misaligned(r.lsu_op, r.addr);
  assign req_raw      = r_mem && busy && !drain;
  assign done_own     = mem_rsp.done && !drain;  // Late completions of flushed work are dropped

  assign stall = busy;

  assign mem_req.req   = req_raw && !flush;
  assign mem_req.write = !is_load(r.lsu_op);
  assign mem_req.addr  = r.addr;
  assign mem_req.wdata = r.sdata;
  assign mem_req.op    = r.lsu_op;

  assign ld_raw     = mem_rsp.rdata;
  assign ld_addr_lo = r.addr[1:0];
  assign ld_op      = r.lsu_op;

  // Loads come back here as plain writebacks once their data is latched
  assign reg_win.wren  = r.valid && r.wren && !is_mem(r.lsu_op) && !flush;
  assign reg_win.waddr = r.waddr;
  assign reg_win.wdata = r.wdata;

  assign exc.valid = r_mem && r_misaligned && !flush;
  assign exc.cause = is_load(r.lsu_op) ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
  assign exc.tval  = r.addr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      r.valid <= 1'b0;
      busy    <= 1'b0;
      pending <= 1'b0;
      drain   <= 1'b0;
    end else begin
      if (mem_rsp.done) begin
        pending <= 1'b0;
        drain   <= 1'b0;
      end else if (mem_req.req) begin
        pending <= 1'b1;
      end

      if (flush) begin
        r.valid <= 1'b0;
        busy    <= 1'b0;
        if (pending && !mem_rsp.done) begin
          drain <= 1'b1;
        end
      end else if (!busy) begin
        r    <= ex_in;
        busy <= ex_in.valid && is_mem(ex_in.lsu_op) && !misaligned(ex_in.lsu_op, ex_in.addr);
      end else if (done_own) begin
        r.lsu_op <= LSU_NONE;                      // Access finished, only writeback remains
        r.wren   <= r.wren && is_load(r.lsu_op);
        r.wdata  <= ld_data;
        busy     <= 1'b0;
      end
    end
  end

  // A misaligned access must never reach the bus
  assert property (@(posedge clk) disable iff (!rst) exc.valid |-> !mem_req.req);

  assert property (@(posedge clk) disable iff (!rst) !(reg_win.wren && stall));

endmodule

// File: rtl/int_regfile.sv
`timescale 1ns/100ps

module int_regfile import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  reg_write_t reg_win,
  input  reg_addr_t  rd_addr,
  output xlen_t      rd_data
);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_win.wren && reg_win.waddr != '0) begin
      regs[reg_win.waddr] <= reg_win.wdata;
    end
  end

  // x0 is hardwired
  assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/100ps

module data_ram import mem_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_in,
  output apb_rsp_t apb_out
);

  xlen_t                 mem [RAM_WORDS];
  logic [RAM_AW-1:0]     idx;
  logic [RAM_WAIT_W-1:0] wait_cnt;
  logic                  access;

  assign idx    = apb_in.paddr[RAM_AW+1:2];  // Upper address bits wrap around
  assign access = apb_in.psel && apb_in.penable;

  assign apb_out.pready = access && (wait_cnt == RAM_WAIT_W'(RAM_WAIT));
  assign apb_out.prdata = mem[idx];

  always_ff @(posedge clk) begin
    if (!rst) begin
      wait_cnt <= '0;
    end else if (access && !apb_out.pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // Byte lanes are written only where pstrb is set
  always_ff @(posedge clk) begin
    if (apb_out.pready && apb_in.pwrite) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (apb_in.pstrb[b]) begin
          mem[idx][8*b +: 8] <= apb_in.pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/apb_data_port.sv
`timescale 1ns/100ps

module apb_data_port import mem_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp,
  output apb_req_t apb_out,
  input  apb_rsp_t apb_in
);

  apb_state_e state;
  apb_state_e phase;
  xlen_t      lane_data;
  strb_t      lane_strb;
  logic       hold_write;
  addr_t      hold_addr;
  xlen_t      hold_wdata;
  strb_t      hold_strb;

  // Replicate store data over all lanes and enable only the addressed ones
  always_comb begin
    case (mem_req.op)
      LSU_SB: begin
        lane_data = {4{mem_req.wdata[7:0]}};
        lane_strb = strb_t'(4'b0001 << mem_req.addr[1:0]);
      end
      LSU_SH: begin
        lane_data = {2{mem_req.wdata[15:0]}};
        lane_strb = mem_req.addr[1] ? 4'b1100 : 4'b0011;
      end
      LSU_SW: begin
        lane_data = mem_req.wdata;
        lane_strb = 4'b1111;
      end
      default: begin
        lane_data = mem_req.wdata;
        lane_strb = '0;
      end
    endcase
  end

  // The setup phase is the IDLE cycle in which a request is seen
  assign phase = (state == APB_IDLE && mem_req.req) ? APB_SETUP : state;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= APB_IDLE;
    end else begin
      case (state)
        APB_IDLE:   if (mem_req.req) state <= APB_ACCESS;
        APB_ACCESS: if (apb_in.pready) state <= APB_IDLE;
        default:    state <= APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == APB_SETUP) begin
      hold_write <= mem_req.write;
      hold_addr  <= mem_req.addr;
      hold_wdata <= lane_data;
      hold_strb  <= lane_strb;
    end
  end

  assign apb_out.psel    = phase != APB_IDLE;
  assign apb_out.penable = phase == APB_ACCESS;
  assign apb_out.pwrite  = (phase == APB_ACCESS) ? hold_write : mem_req.write;
  assign apb_out.paddr   = (phase == APB_ACCESS) ? hold_addr : mem_req.addr;
  assign apb_out.pwdata  = (phase == APB_ACCESS) ? hold_wdata : lane_data;
  assign apb_out.pstrb   = (phase == APB_ACCESS) ? hold_strb : lane_strb;

  assign mem_rsp.done  = (phase == APB_ACCESS) && apb_in.pready;
  assign mem_rsp.rdata = apb_in.prdata;

  assert property (@(posedge clk) disable iff (!rst)
    apb_out.psel && !(apb_out.penable && apb_in.pready) |=>
      $stable(apb_out.paddr) && $stable(apb_out.pwrite) && $stable(apb_out.pwdata));

endmodule

// File: rtl/load_align.sv
`timescale 1ns/100ps

module load_align import mem_pkg::*; (
  input  xlen_t      raw,
  input  logic [1:0] addr_lo,
  input  lsu_op_e    op,
  output xlen_t      data
);

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  assign lane_b = raw[{addr_lo, 3'b000} +: 8];
  assign lane_h = addr_lo[1] ? raw[31:16] : raw[15:0];  // Bit 0 is clear for legal halfwords

  always_comb begin
    case (op)
      LSU_LB: begin
        data = {{24{lane_b[7]}}, lane_b};
      end
      LSU_LBU: begin
        data = {24'h0, lane_b};
      end
      LSU_LH: begin
        data = {{16{lane_h[15]}}, lane_h};
      end
      LSU_LHU: begin
        data = {16'h0, lane_h};
      end
      default: begin
        data = raw;
      end
    endcase
  end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

  localparam int XLEN       = 32;
  localparam int NBYTES     = XLEN / 8;
  localparam int NUM_REGS   = 32;
  localparam int RAM_WORDS  = 256;
  localparam int RAM_AW     = $clog2(RAM_WORDS);
  localparam int RAM_WAIT   = 1;                    // Extra ACCESS cycles before pready
  localparam int RAM_WAIT_W = $clog2(RAM_WAIT + 2);

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [31:0]       addr_t;
  typedef logic [4:0]        reg_addr_t;
  typedef logic [NBYTES-1:0] strb_t;
  typedef logic [3:0]        ecause_t;

  localparam ecause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
  localparam ecause_t CAUSE_STORE_MISALIGNED = 4'd6;

  typedef enum logic [3:0] {
    LSU_LB,
    LSU_LH,
    LSU_LW,
    LSU_LBU,
    LSU_LHU,
    LSU_SB,
    LSU_SH,
    LSU_SW,
    LSU_NONE
  } lsu_op_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  // Record handed over by the execute stage
  typedef struct packed {
    logic      valid;
    logic      wren;
    reg_addr_t waddr;
    xlen_t     wdata;  // ALU result
    lsu_op_e   lsu_op;
    addr_t     addr;
    xlen_t     sdata;
  } ex_mem_t;

  typedef struct packed {
    logic    req;
    logic    write;
    addr_t   addr;
    xlen_t   wdata;
    lsu_op_e op;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    xlen_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    xlen_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    xlen_t prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    xlen_t     wdata;
  } reg_write_t;

  typedef struct packed {
    logic    valid;
    ecause_t cause;
    addr_t   tval;
  } mem_exc_t;

endpackage
